// ==== rs_div_pkg.sv ====
`default_nettype none

package rs_div_pkg;

    // station geometry
    localparam int RS_DEPTH = 16;
    localparam int PTR_W    = 4;   // log2 of RS_DEPTH, ring wraps on overflow

    // instruction fields
    localparam int PC_W     = 32;
    localparam int TAG_W    = 8;   // physical register tag
    localparam int OP_W     = 4;

    // result broadcast ports from the execution units
    localparam int NUM_WAKE = 4;

endpackage

`default_nettype wire

// ==== rs_div_alloc.sv ====
`timescale 1ns/100ps
`default_nettype none

module rs_div_alloc (
    input  wire                                                 clk,
    input  wire                                                 rst_n,
    input  wire                                                 flush,
    input  wire                                                 dispatch_start,
    input  wire [rs_div_pkg::TAG_W-1:0]                         dispatch_src1,
    input  wire [rs_div_pkg::TAG_W-1:0]                         dispatch_src2,
    input  wire [1:0]                                           dispatch_src_ready,
    input  wire [rs_div_pkg::NUM_WAKE-1:0]                      wake_valid,
    input  wire [rs_div_pkg::NUM_WAKE-1:0][rs_div_pkg::TAG_W-1:0] wake_tag,
    output logic [rs_div_pkg::RS_DEPTH-1:0]                     entry_wr,
    output logic                                                wr_ready1,
    output logic                                                wr_ready2
);

    logic [rs_div_pkg::PTR_W-1:0] tail;
    logic                         bypass1;
    logic                         bypass2;

    // next free slot
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            tail <= '0;
        end else if (dispatch_start) begin
            tail <= tail + {{(rs_div_pkg::PTR_W-1){1'b0}}, 1'b1};  // wraps at RS_DEPTH
        end
    end

    // one-hot write select
    always_comb begin
        entry_wr       = '0;
        entry_wr[tail] = dispatch_start;
    end

    // result broadcast in the dispatch cycle itself
    always_comb begin
        bypass1 = 1'b0;
        bypass2 = 1'b0;
        for (int w = 0; w < rs_div_pkg::NUM_WAKE; w++) begin
            if (wake_valid[w] && (wake_tag[w] == dispatch_src1)) begin
                bypass1 = 1'b1;
            end
            if (wake_valid[w] && (wake_tag[w] == dispatch_src2)) begin
                bypass2 = 1'b1;
            end
        end
    end

    assign wr_ready1 = dispatch_src_ready[0] | bypass1;
    assign wr_ready2 = dispatch_src_ready[1] | bypass2;

endmodule

`default_nettype wire

// ==== rs_div_entry.sv ====
`timescale 1ns/100ps
`default_nettype none

module rs_div_entry (
    input  wire                                                 clk,
    input  wire                                                 rst_n,
    input  wire                                                 flush,
    input  wire                                                 wr,
    input  wire                                                 clr,
    input  wire [rs_div_pkg::PC_W-1:0]                          wr_pc,
    input  wire [rs_div_pkg::TAG_W-1:0]                         wr_rd,
    input  wire [rs_div_pkg::OP_W-1:0]                          wr_op,
    input  wire [rs_div_pkg::TAG_W-1:0]                         wr_src1,
    input  wire [rs_div_pkg::TAG_W-1:0]                         wr_src2,
    input  wire                                                 wr_ready1,
    input  wire                                                 wr_ready2,
    input  wire [rs_div_pkg::NUM_WAKE-1:0]                      wake_valid,
    input  wire [rs_div_pkg::NUM_WAKE-1:0][rs_div_pkg::TAG_W-1:0] wake_tag,
    output logic                                                busy,
    output logic                                                ready,
    output logic [rs_div_pkg::PC_W-1:0]                         pc,
    output logic [rs_div_pkg::TAG_W-1:0]                        rd,
    output logic [rs_div_pkg::OP_W-1:0]                         op,
    output logic [rs_div_pkg::TAG_W-1:0]                        src1,
    output logic [rs_div_pkg::TAG_W-1:0]                        src2
);

    logic src1_rdy;
    logic src2_rdy;
    logic wake_hit1;
    logic wake_hit2;

    always_comb begin
        wake_hit1 = 1'b0;
        wake_hit2 = 1'b0;
        for (int w = 0; w < rs_div_pkg::NUM_WAKE; w++) begin
            if (wake_valid[w] && (wake_tag[w] == src1)) begin
                wake_hit1 = 1'b1;
            end
            if (wake_valid[w] && (wake_tag[w] == src2)) begin
                wake_hit2 = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            busy <= 1'b0;
        end else if (wr) begin
            busy <= 1'b1;
        end else if (clr) begin
            busy <= 1'b0;  // issued this edge
        end
    end

    // payload and operand state, masked by busy
    always_ff @(posedge clk) begin
        if (wr) begin
            pc       <= wr_pc;
            rd       <= wr_rd;
            op       <= wr_op;
            src1     <= wr_src1;
            src2     <= wr_src2;
            src1_rdy <= wr_ready1;
            src2_rdy <= wr_ready2;
        end else begin
            if (wake_hit1) src1_rdy <= 1'b1;
            if (wake_hit2) src2_rdy <= 1'b1;
        end
    end

    assign ready = busy & src1_rdy & src2_rdy;

endmodule

`default_nettype wire

// ==== rs_div_issue.sv ====
`timescale 1ns/100ps
`default_nettype none

module rs_div_issue (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              flush,
    input  wire [rs_div_pkg::RS_DEPTH-1:0]   entry_busy,
    input  wire [rs_div_pkg::RS_DEPTH-1:0]   entry_ready,
    input  wire [rs_div_pkg::PC_W-1:0]       entry_pc   [rs_div_pkg::RS_DEPTH],
    input  wire [rs_div_pkg::TAG_W-1:0]      entry_rd   [rs_div_pkg::RS_DEPTH],
    input  wire [rs_div_pkg::OP_W-1:0]       entry_op   [rs_div_pkg::RS_DEPTH],
    input  wire [rs_div_pkg::TAG_W-1:0]      entry_src1 [rs_div_pkg::RS_DEPTH],
    input  wire [rs_div_pkg::TAG_W-1:0]      entry_src2 [rs_div_pkg::RS_DEPTH],
    output logic [rs_div_pkg::RS_DEPTH-1:0]  entry_clr,
    output logic                             issue_valid,
    output logic [rs_div_pkg::PC_W-1:0]      issue_pc,
    output logic [rs_div_pkg::TAG_W-1:0]     issue_rd,
    output logic [rs_div_pkg::OP_W-1:0]      issue_op,
    output logic [rs_div_pkg::TAG_W-1:0]     issue_src1,
    output logic [rs_div_pkg::TAG_W-1:0]     issue_src2
);

    logic [rs_div_pkg::PTR_W-1:0] head;
    logic [rs_div_pkg::PTR_W-1:0] scan_idx;
    logic [rs_div_pkg::PTR_W-1:0] sel_idx;
    logic                         sel_found;

    // oldest entry is the one at head
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            head <= '0;
        end else if (!entry_busy[head] && (|entry_busy)) begin
            head <= head + {{(rs_div_pkg::PTR_W-1){1'b0}}, 1'b1};  // skip a drained slot
        end
    end

    // first ready entry in ring order from head
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        scan_idx  = '0;
        for (int k = 0; k < rs_div_pkg::RS_DEPTH; k++) begin
            scan_idx = head + k[rs_div_pkg::PTR_W-1:0];  // modulo RS_DEPTH
            if (!sel_found && entry_ready[scan_idx]) begin
                sel_found = 1'b1;
                sel_idx   = scan_idx;
            end
        end
    end

    always_comb begin
        entry_clr          = '0;
        entry_clr[sel_idx] = sel_found;
    end

    // fields stay zero while nothing issues
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            issue_valid <= 1'b0;
            issue_pc    <= '0;
            issue_rd    <= '0;
            issue_op    <= '0;
            issue_src1  <= '0;
            issue_src2  <= '0;
        end else if (sel_found) begin
            issue_valid <= 1'b1;
            issue_pc    <= entry_pc[sel_idx];
            issue_rd    <= entry_rd[sel_idx];
            issue_op    <= entry_op[sel_idx];
            issue_src1  <= entry_src1[sel_idx];
            issue_src2  <= entry_src2[sel_idx];
        end else begin
            issue_valid <= 1'b0;
            issue_pc    <= '0;
            issue_rd    <= '0;
            issue_op    <= '0;
            issue_src1  <= '0;
            issue_src2  <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== rs_div_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module rs_div_top (
    input  wire                                                 clk,
    input  wire                                                 rst_n,
    input  wire                                                 flush,
    input  wire                                                 dispatch_start,
    input  wire [rs_div_pkg::PC_W-1:0]                          dispatch_pc,
    input  wire [rs_div_pkg::TAG_W-1:0]                         dispatch_rd,
    input  wire [rs_div_pkg::OP_W-1:0]                          dispatch_op,
    input  wire [rs_div_pkg::TAG_W-1:0]                         dispatch_src1,
    input  wire [rs_div_pkg::TAG_W-1:0]                         dispatch_src2,
    input  wire [1:0]                                           dispatch_src_ready,
    input  wire [rs_div_pkg::NUM_WAKE-1:0]                      wake_valid,
    input  wire [rs_div_pkg::NUM_WAKE-1:0][rs_div_pkg::TAG_W-1:0] wake_tag,
    output logic                                                issue_valid,
    output logic [rs_div_pkg::PC_W-1:0]                         issue_pc,
    output logic [rs_div_pkg::TAG_W-1:0]                        issue_rd,
    output logic [rs_div_pkg::OP_W-1:0]                         issue_op,
    output logic [rs_div_pkg::TAG_W-1:0]                        issue_src1,
    output logic [rs_div_pkg::TAG_W-1:0]                        issue_src2
);

    logic [rs_div_pkg::RS_DEPTH-1:0] entry_wr;
    logic [rs_div_pkg::RS_DEPTH-1:0] entry_clr;
    logic [rs_div_pkg::RS_DEPTH-1:0] entry_busy;
    logic [rs_div_pkg::RS_DEPTH-1:0] entry_ready;
    logic                            wr_ready1;
    logic                            wr_ready2;
    logic [rs_div_pkg::PC_W-1:0]     entry_pc   [rs_div_pkg::RS_DEPTH];
    logic [rs_div_pkg::TAG_W-1:0]    entry_rd   [rs_div_pkg::RS_DEPTH];
    logic [rs_div_pkg::OP_W-1:0]     entry_op   [rs_div_pkg::RS_DEPTH];
    logic [rs_div_pkg::TAG_W-1:0]    entry_src1 [rs_div_pkg::RS_DEPTH];
    logic [rs_div_pkg::TAG_W-1:0]    entry_src2 [rs_div_pkg::RS_DEPTH];

    rs_div_alloc u_alloc (
        .clk                (clk),
        .rst_n              (rst_n),
        .flush              (flush),
        .dispatch_start     (dispatch_start),
        .dispatch_src1      (dispatch_src1),
        .dispatch_src2      (dispatch_src2),
        .dispatch_src_ready (dispatch_src_ready),
        .wake_valid         (wake_valid),
        .wake_tag           (wake_tag),
        .entry_wr           (entry_wr),
        .wr_ready1          (wr_ready1),
        .wr_ready2          (wr_ready2)
    );

    // write fields are shared, entry_wr picks the slot
    for (genvar i = 0; i < rs_div_pkg::RS_DEPTH; i++) begin : g_entry
        rs_div_entry u_entry (
            .clk        (clk),
            .rst_n      (rst_n),
            .flush      (flush),
            .wr         (entry_wr[i]),
            .clr        (entry_clr[i]),
            .wr_pc      (dispatch_pc),
            .wr_rd      (dispatch_rd),
            .wr_op      (dispatch_op),
            .wr_src1    (dispatch_src1),
            .wr_src2    (dispatch_src2),
            .wr_ready1  (wr_ready1),
            .wr_ready2  (wr_ready2),
            .wake_valid (wake_valid),
            .wake_tag   (wake_tag),
            .busy       (entry_busy[i]),
            .ready      (entry_ready[i]),
            .pc         (entry_pc[i]),
            .rd         (entry_rd[i]),
            .op         (entry_op[i]),
            .src1       (entry_src1[i]),
            .src2       (entry_src2[i])
        );
    end

    rs_div_issue u_issue (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .entry_busy  (entry_busy),
        .entry_ready (entry_ready),
        .entry_pc    (entry_pc),
        .entry_rd    (entry_rd),
        .entry_op    (entry_op),
        .entry_src1  (entry_src1),
        .entry_src2  (entry_src2),
        .entry_clr   (entry_clr),
        .issue_valid (issue_valid),
        .issue_pc    (issue_pc),
        .issue_rd    (issue_rd),
        .issue_op    (issue_op),
        .issue_src1  (issue_src1),
        .issue_src2  (issue_src2)
    );

endmodule

`default_nettype wire

// ==== rs_div_asserts.sv ====
`timescale 1ns/100ps
`default_nettype none

module rs_div_asserts (
    input wire                                                 clk,
    input wire                                                 rst_n,
    input wire                                                 flush,
    input wire                                                 dispatch_start,
    input wire [rs_div_pkg::PC_W-1:0]                          dispatch_pc,
    input wire [rs_div_pkg::TAG_W-1:0]                         dispatch_rd,
    input wire [rs_div_pkg::OP_W-1:0]                          dispatch_op,
    input wire [rs_div_pkg::TAG_W-1:0]                         dispatch_src1,
    input wire [rs_div_pkg::TAG_W-1:0]                         dispatch_src2,
    input wire [1:0]                                           dispatch_src_ready,
    input wire [rs_div_pkg::NUM_WAKE-1:0]                      wake_valid,
    input wire [rs_div_pkg::NUM_WAKE-1:0][rs_div_pkg::TAG_W-1:0] wake_tag,
    input wire [rs_div_pkg::RS_DEPTH-1:0]                      entry_wr,
    input wire [rs_div_pkg::RS_DEPTH-1:0]                      entry_busy,
    input wire                                                 issue_valid,
    input wire [rs_div_pkg::PC_W-1:0]                          issue_pc,
    input wire [rs_div_pkg::TAG_W-1:0]                         issue_rd,
    input wire [rs_div_pkg::OP_W-1:0]                          issue_op,
    input wire [rs_div_pkg::TAG_W-1:0]                         issue_src1,
    input wire [rs_div_pkg::TAG_W-1:0]                         issue_src2
);

    int                            fail_cnt = 0;
    logic [rs_div_pkg::NUM_WAKE-1:0] hit1;
    logic [rs_div_pkg::NUM_WAKE-1:0] hit2;
    logic                          fresh_ready;

    // broadcasts naming a dispatch source this cycle
    for (genvar w = 0; w < rs_div_pkg::NUM_WAKE; w++) begin : g_hit
        assign hit1[w] = wake_valid[w] && (wake_tag[w] == dispatch_src1);
        assign hit2[w] = wake_valid[w] && (wake_tag[w] == dispatch_src2);
    end

    // ready instruction entering an empty station
    assign fresh_ready = rst_n && !flush && dispatch_start
                         && (dispatch_src_ready[0] || (|hit1))
                         && (dispatch_src_ready[1] || (|hit2))
                         && (entry_busy == '0);

    a_flush_quiet: assert property (@(posedge clk) (!rst_n || flush) |=> !issue_valid)
        else begin
            fail_cnt++;
            $error("ERR %0t: issue_valid high after reset or flush", $time);
        end

    a_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n)
        dispatch_start |-> ((entry_wr & entry_busy) == '0))
        else begin
            fail_cnt++;
            $error("ERR %0t: dispatch onto a busy entry", $time);
        end

    a_idle_zero: assert property (@(posedge clk) !issue_valid |->
        (issue_pc == '0 && issue_rd == '0 && issue_op == '0
         && issue_src1 == '0 && issue_src2 == '0))
        else begin
            fail_cnt++;
            $error("ERR %0t: issue fields not zero while idle", $time);
        end

    // two edges from dispatch to issue
    a_latency: assert property (@(posedge clk) disable iff (!rst_n || flush)
        ($past(fresh_ready, 2) && !$past(flush)) |->
        (issue_valid && issue_pc == $past(dispatch_pc, 2) && issue_rd == $past(dispatch_rd, 2)
         && issue_op == $past(dispatch_op, 2) && issue_src1 == $past(dispatch_src1, 2)
         && issue_src2 == $past(dispatch_src2, 2)))
        else begin
            fail_cnt++;
            $error("ERR %0t: ready dispatch not issued as sent", $time);
        end

    a_once: assert property (@(posedge clk) disable iff (!rst_n)
        (issue_valid && $past(issue_valid)) |-> (issue_pc != $past(issue_pc)))
        else begin
            fail_cnt++;
            $error("ERR %0t: same pc issued twice", $time);
        end

endmodule

bind rs_div_top rs_div_asserts u_chk (
    .clk(clk), .rst_n(rst_n), .flush(flush), .dispatch_start(dispatch_start),
    .dispatch_pc(dispatch_pc), .dispatch_rd(dispatch_rd), .dispatch_op(dispatch_op),
    .dispatch_src1(dispatch_src1), .dispatch_src2(dispatch_src2),
    .dispatch_src_ready(dispatch_src_ready), .wake_valid(wake_valid), .wake_tag(wake_tag),
    .entry_wr(entry_wr), .entry_busy(entry_busy), .issue_valid(issue_valid),
    .issue_pc(issue_pc), .issue_rd(issue_rd), .issue_op(issue_op),
    .issue_src1(issue_src1), .issue_src2(issue_src2)
);

`default_nettype wire

// ==== tb_rs_div.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rs_div;

    localparam int  TIMEOUT    = 50;
    localparam time CLK_PERIOD = 40;
    localparam time ISSUE_LAG  = 2 * CLK_PERIOD;  // dispatch or wakeup to issue

    logic        clk = 1'b0;
    logic        rst_n, flush, dispatch_start;
    logic [31:0] dispatch_pc;
    logic [7:0]  dispatch_rd, dispatch_src1, dispatch_src2;
    logic [3:0]  dispatch_op;
    logic [1:0]  dispatch_src_ready;
    logic [3:0]  wake_valid;
    logic [3:0][7:0] wake_tag;
    logic        issue_valid;
    logic [31:0] issue_pc;
    logic [7:0]  issue_rd, issue_src1, issue_src2;
    logic [3:0]  issue_op;

    logic [31:0] lcg_state = 32'h46684dd4;
    logic [7:0]  seq = 8'd0;
    logic [31:0] issued[$];
    time         issued_t[$];
    int          next_idx = 0;
    int          errors = 0;
    logic [31:0] pa, pb, pc3;
    logic [31:0] rnd;
    time         t_drv;

    rs_div_top UUT (.*);

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // issue_valid is a one-cycle pulse, so record every one with its time
    always @(negedge clk) begin
        if (rst_n && issue_valid) begin
            issued.push_back(issue_pc);
            issued_t.push_back($time);
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // drive one dispatch, returns one falling edge later
    task automatic put(output logic [31:0] pc, input logic [7:0] s2, input logic [1:0] rdy);
        logic [31:0] r;
        r = lcg_next();
        seq = seq + 8'd1;
        pc = {r[31:8], seq};  // low byte keeps pcs distinct
        dispatch_start = 1'b1;
        dispatch_pc = pc;
        dispatch_rd = r[7:0];
        dispatch_op = r[11:8];
        dispatch_src1 = r[19:12];
        dispatch_src2 = s2;
        dispatch_src_ready = rdy;
        @(negedge clk);
    endtask

    task automatic idle(input int n);
        dispatch_start = 1'b0;
        wake_valid = '0;
        flush = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic expect_issue(input logic [31:0] pc, input time due);
        int n;
        for (n = 0; n < TIMEOUT && issued.size() <= next_idx; n++) @(negedge clk);
        if (issued.size() <= next_idx) begin
            errors++;
            $display("timed out waiting for pc %h to issue", pc);
        end else begin
            if (issued[next_idx] != pc) begin
                errors++;
                $display("ERR %0t: issued pc %h, expected %h", $time, issued[next_idx], pc);
            end else if (issued_t[next_idx] != due) begin
                errors++;
                $display("ERR %0t: pc %h issued at %0t, expected at %0t", $time, pc,
                         issued_t[next_idx], due);
            end
            next_idx++;
        end
    endtask

    task automatic expect_none(input int n);
        idle(n);
        if (issued.size() != next_idx) begin
            errors++;
            $display("ERR %0t: unexpected issue of pc %h", $time, issued[next_idx]);
            next_idx = issued.size();
        end
    endtask

    initial begin
        rst_n = 1'b0;
        flush = 1'b0;
        dispatch_start = 1'b0;
        dispatch_pc = '0;
        dispatch_rd = '0;
        dispatch_op = '0;
        dispatch_src1 = '0;
        dispatch_src2 = '0;
        dispatch_src_ready = '0;
        wake_valid = '0;
        wake_tag = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        expect_none(4);

        rnd = lcg_next();
        t_drv = $time;
        put(pa, rnd[7:0], 2'b11);  // both ready
        idle(0);
        expect_issue(pa, t_drv + ISSUE_LAG);

        wake_valid = 4'b0100;  // broadcast in the dispatch cycle
        wake_tag[2] = 8'h3c;
        t_drv = $time;
        put(pa, 8'h3c, 2'b01);
        idle(0);
        expect_issue(pa, t_drv + ISSUE_LAG);

        put(pa, 8'ha5, 2'b01);  // waits on a5
        expect_none(5);
        wake_valid = 4'b0001;
        wake_tag[0] = 8'ha5;
        t_drv = $time;
        @(negedge clk);
        idle(0);
        expect_issue(pa, t_drv + ISSUE_LAG);

        put(pa, 8'h5a, 2'b01);  // older, waiting
        t_drv = $time;
        put(pb, 8'h11, 2'b11);  // younger, ready
        idle(0);
        expect_issue(pb, t_drv + ISSUE_LAG);
        expect_none(3);
        wake_valid = 4'b1000;
        wake_tag[3] = 8'h5a;
        t_drv = $time;
        @(negedge clk);
        idle(0);
        expect_issue(pa, t_drv + ISSUE_LAG);

        put(pa, 8'h77, 2'b01);
        idle(1);
        flush = 1'b1;
        @(negedge clk);
        idle(0);
        wake_valid = 4'b0010;
        wake_tag[1] = 8'h77;
        @(negedge clk);
        expect_none(4);

        t_drv = $time;
        put(pa, 8'h01, 2'b11);
        put(pb, 8'h02, 2'b11);
        put(pc3, 8'h03, 2'b11);
        idle(0);
        expect_issue(pa, t_drv + ISSUE_LAG);
        expect_issue(pb, t_drv + ISSUE_LAG + CLK_PERIOD);
        expect_issue(pc3, t_drv + ISSUE_LAG + 2 * CLK_PERIOD);
        expect_none(4);

        $display("errors %0d, assertion failures %0d, issues %0d",
                 errors, UUT.u_chk.fail_cnt, issued.size());
        if (errors == 0 && UUT.u_chk.fail_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
rs_div_pkg.sv
rs_div_alloc.sv
rs_div_entry.sv
rs_div_issue.sv
rs_div_top.sv
rs_div_asserts.sv
tb_rs_div.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the reservation station testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rs_div -f src.f -o sim_rs_div
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_rs_div +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" <<< "$out"; then
    exit 0
fi
exit 1
